// ==== hdl/risk_params.svh ====
// widths and table size shared by the risk gate packages and ledgers
// include in any file that sizes a client table or a payload field

`ifndef RISK_PARAMS_SVH
`define RISK_PARAMS_SVH

// client id width, one ledger entry per id
`define RISK_CLIENT_W 5

// ledger depth, must equal 2**RISK_CLIENT_W
`define RISK_NUM_CLIENTS 32

// order amounts, limits and accumulated totals
`define RISK_AMOUNT_W 32

// exchange cancel amounts and cancelled totals
`define RISK_CANCEL_W 16

`endif

// ==== hdl/order_pkg.sv ====
// request and response types of the risk gate
// used by decode, execute, result and the top level through scoped names

`include "risk_params.svh"

package order_pkg;

  // payload field types
  typedef logic [`RISK_CLIENT_W-1:0] client_t;
  typedef logic [`RISK_AMOUNT_W-1:0] amount_t;
  typedef logic [`RISK_CANCEL_W-1:0] cancel_t;

  // decoded request kind
  typedef enum logic
  {
    OP_SET_LIMIT = 1'b0,
    OP_NEW_ORDER = 1'b1
  } opcode_e;

  // response kind returned to the cpu
  typedef enum logic [1:0]
  {
    V_LIMIT_SET = 2'd0,
    V_ACCEPTED  = 2'd1,
    V_REJECTED  = 2'd2
  } verdict_e;

endpackage

// ==== hdl/engine_pkg.sv ====
// state encoding of the execute stage
// referenced by risk_execute through scoped names

package engine_pkg;

  // one request walks idle, read, check, commit
  typedef enum logic [1:0]
  {
    // waiting for a decoded item
    S_IDLE   = 2'd0,
    // ledger address presented, entries captured
    S_READ   = 2'd1,
    // exposure compared with limit
    S_CHECK  = 2'd2,
    // ledger written, verdict offered
    S_COMMIT = 2'd3
  } exec_state_e;

endpackage

// ==== hdl/order_decode.sv ====
// first stage of the risk gate, takes cpu requests into a one-entry register
// the set-limit flag is turned into an opcode for the execute stage

module order_decode
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  order_pkg::client_t     req_client,
  input  order_pkg::amount_t     req_amount,
  input  logic                   req_new_limit,
  input  logic                   dec_ready,
  output logic                   req_ready,
  output logic                   dec_valid,
  output order_pkg::opcode_e     dec_op,
  output order_pkg::client_t     dec_client,
  output order_pkg::amount_t     dec_amount
);

  // space when empty or when the held item leaves this cycle
  assign req_ready = !dec_valid || dec_ready;

  // occupancy flag
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      dec_valid <= 1'b0;
    end
    else if (req_valid && req_ready)
    begin
      dec_valid <= 1'b1;
    end
    else if (dec_ready)
    begin
      dec_valid <= 1'b0;
    end
  end

  // payload, loaded only on the request handshake
  always_ff @(posedge clk)
  begin
    if (req_valid && req_ready)
    begin
      dec_op     <= req_new_limit ? order_pkg::OP_SET_LIMIT : order_pkg::OP_NEW_ORDER;
      dec_client <= req_client;
      dec_amount <= req_amount;
    end
  end

  // held item must not change while execute is busy
  a_dec_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (dec_valid && !dec_ready) |=> (dec_valid && $stable(dec_op) && $stable(dec_amount))
  );

endmodule

// ==== hdl/client_ledger.sv ====
// per-client limit and accumulated-total table beside the execute stage
// combinational read port, single commit write port driven by execute

`include "risk_params.svh"

module client_ledger
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  order_pkg::client_t     rd_client,
  input  logic                   wr_en,
  input  order_pkg::client_t     wr_client,
  input  order_pkg::amount_t     wr_limit,
  input  order_pkg::amount_t     wr_accum,
  output order_pkg::amount_t     rd_limit,
  output order_pkg::amount_t     rd_accum
);

  // trading limit per client
  order_pkg::amount_t limit_q [`RISK_NUM_CLIENTS];
  // running total of accepted orders per client
  order_pkg::amount_t accum_q [`RISK_NUM_CLIENTS];

  // both fields written together, execute keeps the untouched one as read
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `RISK_NUM_CLIENTS; i++)
      begin
        limit_q[i] <= '0;
        accum_q[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      limit_q[wr_client] <= wr_limit;
      accum_q[wr_client] <= wr_accum;
    end
  end

  // read straight from the registers
  // a write lands on the edge, so it shows up the cycle after
  assign rd_limit = limit_q[rd_client];
  assign rd_accum = accum_q[rd_client];

endmodule

// ==== hdl/cancel_ledger.sv ====
// per-client totals of exchange cancels, saturating at all ones
// written directly by the exchange feed, read combinationally by execute

`include "risk_params.svh"

module cancel_ledger
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cancel_valid,
  input  order_pkg::client_t     cancel_client,
  input  order_pkg::cancel_t     cancel_amount,
  input  order_pkg::client_t     rd_client,
  output order_pkg::cancel_t     rd_cancelled
);

  // cancelled total per client
  order_pkg::cancel_t total_q [`RISK_NUM_CLIENTS];

  // one extra bit to catch the carry out
  logic [`RISK_CANCEL_W:0] sum;

  assign sum = {1'b0, total_q[cancel_client]} + {1'b0, cancel_amount};

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `RISK_NUM_CLIENTS; i++)
      begin
        total_q[i] <= '0;
      end
    end
    else if (cancel_valid)
    begin
      // clamp on carry
      total_q[cancel_client] <= sum[`RISK_CANCEL_W] ? '1 : sum[`RISK_CANCEL_W-1:0];
    end
  end

  // no bypass, a same-cycle cancel is not seen by the read
  assign rd_cancelled = total_q[rd_client];

  // totals only grow between resets
  for (genvar g = 0; g < `RISK_NUM_CLIENTS; g++)
  begin : g_mono
    a_total_monotonic: assert property (
      @(posedge clk) disable iff (!rst_n)
      1'b1 |=> (total_q[g] >= $past(total_q[g]))
    );
  end

endmodule

// ==== hdl/risk_execute.sv ====
// execute stage of the risk gate
// reads both ledgers, runs the risk check and commits the outcome
// one item at a time through idle, read, check and commit

module risk_execute
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dec_valid,
  input  order_pkg::opcode_e     dec_op,
  input  order_pkg::client_t     dec_client,
  input  order_pkg::amount_t     dec_amount,
  input  order_pkg::amount_t     rd_limit,
  input  order_pkg::amount_t     rd_accum,
  input  order_pkg::cancel_t     rd_cancelled,
  input  logic                   exe_ready,
  output logic                   dec_ready,
  output order_pkg::client_t     rd_client,
  output logic                   wr_en,
  output order_pkg::client_t     wr_client,
  output order_pkg::amount_t     wr_limit,
  output order_pkg::amount_t     wr_accum,
  output logic                   exe_valid,
  output order_pkg::client_t     exe_client,
  output order_pkg::verdict_e    exe_verdict
);

  // two guard bits so the sum of two amounts plus a sign never wraps
  localparam int EXP_W = $bits(order_pkg::amount_t) + 2;

  engine_pkg::exec_state_e state;

  // item taken from decode
  order_pkg::opcode_e  item_op;
  order_pkg::client_t  item_client;
  order_pkg::amount_t  item_amount;

  // ledger entries captured in S_READ
  order_pkg::amount_t  limit_q;
  order_pkg::amount_t  accum_q;
  order_pkg::cancel_t  cancel_q;

  // commit already issued for this item
  logic                wr_done;

  logic signed [EXP_W-1:0] exposure;
  logic signed [EXP_W-1:0] limit_wide;
  logic                    over_limit;

  // accumulated plus amount minus cancelled can go negative
  assign exposure = $signed({2'b00, accum_q}) + $signed({2'b00, item_amount})
                  - $signed({{(EXP_W - $bits(order_pkg::cancel_t)){1'b0}}, cancel_q});
  assign limit_wide = $signed({2'b00, limit_q});

  // set-less-than check where limit < exposure breaks the limit
  assign over_limit = limit_wide < exposure;

  assign dec_ready = (state == engine_pkg::S_IDLE);
  assign rd_client = item_client;
  assign wr_client = item_client;
  assign exe_client = item_client;

  // single write on the first commit cycle even while result stalls
  assign wr_en = (state == engine_pkg::S_COMMIT) && !wr_done;

  // control
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= engine_pkg::S_IDLE;
      exe_valid <= 1'b0;
      wr_done   <= 1'b0;
    end
    else
    begin
      case (state)
        engine_pkg::S_IDLE:
        begin
          if (dec_valid)
          begin
            state <= engine_pkg::S_READ;
          end
        end
        engine_pkg::S_READ:
        begin
          state <= engine_pkg::S_CHECK;
        end
        engine_pkg::S_CHECK:
        begin
          state     <= engine_pkg::S_COMMIT;
          exe_valid <= 1'b1;
        end
        default:
        begin
          if (exe_ready)
          begin
            state     <= engine_pkg::S_IDLE;
            exe_valid <= 1'b0;
            wr_done   <= 1'b0;
          end
          else
          begin
            wr_done <= 1'b1;
          end
        end
      endcase
    end
  end

  // datapath registers
  always_ff @(posedge clk)
  begin
    if (state == engine_pkg::S_IDLE && dec_valid)
    begin
      item_op     <= dec_op;
      item_client <= dec_client;
      item_amount <= dec_amount;
    end
    if (state == engine_pkg::S_READ)
    begin
      limit_q  <= rd_limit;
      accum_q  <= rd_accum;
      cancel_q <= rd_cancelled;
    end
    if (state == engine_pkg::S_CHECK)
    begin
      if (item_op == order_pkg::OP_SET_LIMIT)
      begin
        // new limit with the total kept
        exe_verdict <= order_pkg::V_LIMIT_SET;
        wr_limit    <= item_amount;
        wr_accum    <= accum_q;
      end
      else if (over_limit)
      begin
        // rewrite the same entry
        exe_verdict <= order_pkg::V_REJECTED;
        wr_limit    <= limit_q;
        wr_accum    <= accum_q;
      end
      else
      begin
        exe_verdict <= order_pkg::V_ACCEPTED;
        wr_limit    <= limit_q;
        wr_accum    <= accum_q + item_amount;
      end
    end
  end

  // no second write pulse for the same item
  a_wr_once: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |=> !wr_en
  );

  // offer only while committing
  a_valid_in_commit: assert property (
    @(posedge clk) disable iff (!rst_n)
    exe_valid |-> (state == engine_pkg::S_COMMIT)
  );

endmodule

// ==== hdl/order_result.sv ====
// last stage, holds one response until the cpu side takes it
// frees its slot in the same cycle as the consumer handshake

module order_result
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   exe_valid,
  input  order_pkg::client_t     exe_client,
  input  order_pkg::verdict_e    exe_verdict,
  input  logic                   resp_ready,
  output logic                   exe_ready,
  output logic                   resp_valid,
  output order_pkg::client_t     resp_client,
  output order_pkg::verdict_e    resp_verdict
);

  // space when empty or draining
  assign exe_ready = !resp_valid || resp_ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      resp_valid <= 1'b0;
    end
    else if (exe_valid && exe_ready)
    begin
      resp_valid <= 1'b1;
    end
    else if (resp_ready)
    begin
      resp_valid <= 1'b0;
    end
  end

  // response payload
  always_ff @(posedge clk)
  begin
    if (exe_valid && exe_ready)
    begin
      resp_client  <= exe_client;
      resp_verdict <= exe_verdict;
    end
  end

  // stalled response stays put
  a_resp_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (resp_valid && !resp_ready) |=>
      (resp_valid && $stable(resp_client) && $stable(resp_verdict))
  );

endmodule

// ==== hdl/risk_gate_top.sv ====
// pre-trade risk gate, cpu requests in, verdicts out, exchange cancels on the side
// decode, execute and result in a row with both ledgers beside execute

module risk_gate_top
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  order_pkg::client_t     req_client,
  input  order_pkg::amount_t     req_amount,
  input  logic                   req_new_limit,
  input  logic                   cancel_valid,
  input  order_pkg::client_t     cancel_client,
  input  order_pkg::cancel_t     cancel_amount,
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output order_pkg::client_t     resp_client,
  output order_pkg::verdict_e    resp_verdict
);

  // decode to execute
  logic                dec_valid;
  logic                dec_ready;
  order_pkg::opcode_e  dec_op;
  order_pkg::client_t  dec_client;
  order_pkg::amount_t  dec_amount;

  // ledger ports
  order_pkg::client_t  rd_client;
  order_pkg::amount_t  rd_limit;
  order_pkg::amount_t  rd_accum;
  order_pkg::cancel_t  rd_cancelled;
  logic                wr_en;
  order_pkg::client_t  wr_client;
  order_pkg::amount_t  wr_limit;
  order_pkg::amount_t  wr_accum;

  // execute to result
  logic                exe_valid;
  logic                exe_ready;
  order_pkg::client_t  exe_client;
  order_pkg::verdict_e exe_verdict;

  order_decode u_decode
  (
    .clk(clk), .rst_n(rst_n),
    .req_valid(req_valid), .req_client(req_client), .req_amount(req_amount),
    .req_new_limit(req_new_limit), .dec_ready(dec_ready), .req_ready(req_ready),
    .dec_valid(dec_valid), .dec_op(dec_op), .dec_client(dec_client),
    .dec_amount(dec_amount)
  );

  risk_execute u_execute
  (
    .clk(clk), .rst_n(rst_n),
    .dec_valid(dec_valid), .dec_op(dec_op), .dec_client(dec_client),
    .dec_amount(dec_amount), .rd_limit(rd_limit), .rd_accum(rd_accum),
    .rd_cancelled(rd_cancelled), .exe_ready(exe_ready), .dec_ready(dec_ready),
    .rd_client(rd_client), .wr_en(wr_en), .wr_client(wr_client),
    .wr_limit(wr_limit), .wr_accum(wr_accum), .exe_valid(exe_valid),
    .exe_client(exe_client), .exe_verdict(exe_verdict)
  );

  client_ledger u_client_ledger
  (
    .clk(clk), .rst_n(rst_n),
    .rd_client(rd_client), .wr_en(wr_en), .wr_client(wr_client),
    .wr_limit(wr_limit), .wr_accum(wr_accum),
    .rd_limit(rd_limit), .rd_accum(rd_accum)
  );

  // exchange feed writes this one directly
  cancel_ledger u_cancel_ledger
  (
    .clk(clk), .rst_n(rst_n),
    .cancel_valid(cancel_valid), .cancel_client(cancel_client),
    .cancel_amount(cancel_amount), .rd_client(rd_client),
    .rd_cancelled(rd_cancelled)
  );

  order_result u_result
  (
    .clk(clk), .rst_n(rst_n),
    .exe_valid(exe_valid), .exe_client(exe_client), .exe_verdict(exe_verdict),
    .resp_ready(resp_ready), .exe_ready(exe_ready), .resp_valid(resp_valid),
    .resp_client(resp_client), .resp_verdict(resp_verdict)
  );

endmodule

// ==== test/risk_gate_tb.sv ====
// self-checking testbench for the risk gate, replays the vector file line by line
// bursts draw random requests from an LFSR, verdicts predicted by a ledger model

`include "risk_params.svh"

module risk_gate_tb;

  logic                clk;
  logic                rst_n;
  logic                req_valid;
  logic                req_ready;
  order_pkg::client_t  req_client;
  order_pkg::amount_t  req_amount;
  logic                req_new_limit;
  logic                cancel_valid;
  order_pkg::client_t  cancel_client;
  order_pkg::cancel_t  cancel_amount;
  logic                resp_valid;
  logic                resp_ready;
  order_pkg::client_t  resp_client;
  order_pkg::verdict_e resp_verdict;

  // reference ledgers
  order_pkg::amount_t m_limit [`RISK_NUM_CLIENTS];
  order_pkg::amount_t m_accum [`RISK_NUM_CLIENTS];
  order_pkg::cancel_t m_cancel [`RISK_NUM_CLIENTS];

  // outstanding responses, oldest first
  order_pkg::verdict_e exp_verdict_q [$];
  order_pkg::client_t  exp_client_q [$];
  string               exp_name_q [$];

  string       test_name = "reset";
  logic [15:0] req_lfsr = 16'd37984;
  logic [15:0] stall_lfsr = 16'd37984;
  logic        stall_mode = 1'b0;
  logic        saw_full = 1'b0;

  risk_gate_top dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // galois lfsr, one step per bit, separate streams for requests and stalls
  function automatic logic [31:0] take_bits(input int n, input logic from_stall);
    logic [31:0] bits;
    logic [15:0] st;
    bits = '0;
    st = from_stall ? stall_lfsr : req_lfsr;
    for (int i = 0; i < n; i++)
    begin
      bits = {bits[30:0], st[0]};
      st = st[0] ? ((st >> 1) ^ 16'hB400) : (st >> 1);
    end
    if (from_stall)
      stall_lfsr = st;
    else
      req_lfsr = st;
    return bits;
  endfunction

  task automatic stop_run(input string what);
    engine_pkg::exec_state_e st;
    st = dut.u_execute.state;
    $display("%s", what);
    $display("execute stage was in %s", st.name());
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_verdict(input string name, input order_pkg::verdict_e exp,
                               input order_pkg::verdict_e act);
    if (act !== exp)
      stop_run($sformatf("Error %s: verdict expected %0d (%s) actual %0d (%s)",
                         name, exp, exp.name(), act, act.name()));
  endtask

  task automatic check_client(input string name, input order_pkg::client_t exp,
                              input order_pkg::client_t act);
    if (act !== exp)
      stop_run($sformatf("Error %s: client expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp)
      stop_run($sformatf("Error %s: latency expected %0d actual %0d", name, exp, act));
  endtask

  // limit rule: accum + amount - cancelled must not exceed limit, no wrap
  function automatic order_pkg::verdict_e model_request(input order_pkg::client_t c,
                                                        input order_pkg::amount_t a,
                                                        input logic set_lim);
    longint exposure;
    if (set_lim)
    begin
      m_limit[c] = a;
      return order_pkg::V_LIMIT_SET;
    end
    exposure = longint'({32'd0, m_accum[c]}) + longint'({32'd0, a})
             - longint'({48'd0, m_cancel[c]});
    if (exposure > longint'({32'd0, m_limit[c]}))
      return order_pkg::V_REJECTED;
    m_accum[c] = m_accum[c] + a;
    return order_pkg::V_ACCEPTED;
  endfunction

  function automatic order_pkg::verdict_e parse_verdict(input string s);
    if (s == "LIMIT")
      return order_pkg::V_LIMIT_SET;
    else if (s == "ACCEPT")
      return order_pkg::V_ACCEPTED;
    return order_pkg::V_REJECTED;
  endfunction

  // all drive tasks start and end 2 units after a rising edge
  task automatic send_request(input order_pkg::client_t c, input order_pkg::amount_t a,
                              input logic set_lim, input order_pkg::verdict_e exp);
    int wait_cyc;
    wait_cyc = 0;
    req_valid = 1'b1;
    req_client = c;
    req_amount = a;
    req_new_limit = set_lim;
    @(negedge clk);
    while (!req_ready)
    begin
      wait_cyc++;
      if (wait_cyc > 200)
        stop_run("request was not accepted within 200 cycles");
      @(negedge clk);
    end
    // handshake on the coming edge
    exp_verdict_q.push_back(exp);
    exp_client_q.push_back(c);
    exp_name_q.push_back(test_name);
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int wait_cyc;
    wait_cyc = 0;
    while (exp_verdict_q.size() != 0 || resp_valid)
    begin
      @(posedge clk);
      #2;
      wait_cyc++;
      if (wait_cyc > 200)
        stop_run("pipeline did not drain within 200 cycles");
    end
  endtask

  // cancels only with nothing in flight
  task automatic send_cancel(input order_pkg::client_t c, input order_pkg::cancel_t a);
    int total;
    wait_drain();
    total = int'(m_cancel[c]) + int'(a);
    if (total > (1 << `RISK_CANCEL_W) - 1)
      total = (1 << `RISK_CANCEL_W) - 1;
    m_cancel[c] = order_pkg::cancel_t'(total);
    cancel_valid = 1'b1;
    cancel_client = c;
    cancel_amount = a;
    @(posedge clk);
    #2;
    cancel_valid = 1'b0;
  endtask

  task automatic measure_latency();
    int lat;
    lat = 0;
    while (!resp_valid)
    begin
      @(posedge clk);
      #2;
      lat++;
      if (lat > 200)
        stop_run("no response within 200 cycles of the request");
    end
    check_latency(test_name, 4, lat);
  endtask

  // random requests to clients 8..15 under random back-pressure
  task automatic run_burst(input int count);
    order_pkg::client_t c;
    order_pkg::amount_t a;
    logic s;
    saw_full = 1'b0;
    stall_mode = 1'b1;
    for (int i = 0; i < count; i++)
    begin
      c = 5'd8 | 5'(take_bits(3, 1'b0));
      s = (take_bits(2, 1'b0) == 0);
      a = take_bits(12, 1'b0);
      send_request(c, a, s, model_request(c, a, s));
    end
    stall_mode = 1'b0;
    wait_drain();
    if (!saw_full)
      stop_run("req_ready never dropped while responses were stalled");
  endtask

  // response check on the falling edge ahead of the consuming rising edge
  always @(negedge clk)
  begin
    if (stall_mode && req_valid && !req_ready)
      saw_full = 1'b1;
    if (rst_n && resp_valid && resp_ready)
    begin
      if (exp_verdict_q.size() == 0)
        stop_run("response arrived with no request outstanding");
      check_verdict(exp_name_q[0], exp_verdict_q[0], resp_verdict);
      check_client(exp_name_q[0], exp_client_q[0], resp_client);
      void'(exp_verdict_q.pop_front());
      void'(exp_client_q.pop_front());
      void'(exp_name_q.pop_front());
    end
  end

  // resp_ready, stalls of 8 to 15 cycles between short ready stretches
  initial
  begin : stall_gen
    int stretch;
    resp_ready = 1'b1;
    stretch = 0;
    forever
    begin
      @(posedge clk);
      #2;
      if (!stall_mode)
      begin
        resp_ready = 1'b1;
        stretch = 0;
      end
      else if (stretch == 0)
      begin
        resp_ready = !resp_ready;
        stretch = resp_ready ? int'(take_bits(3, 1'b1)) : int'(take_bits(3, 1'b1)) + 8;
      end
      else
        stretch--;
    end
  end

  initial
  begin : main
    int fd;
    int cnt;
    string line;
    string kind;
    string vtxt;
    order_pkg::client_t c;
    order_pkg::amount_t a;
    order_pkg::cancel_t ca;
    logic s;
    order_pkg::verdict_e file_v;
    rst_n = 1'b0;
    req_valid = 1'b0;
    req_client = '0;
    req_amount = '0;
    req_new_limit = 1'b0;
    cancel_valid = 1'b0;
    cancel_client = '0;
    cancel_amount = '0;
    for (int i = 0; i < `RISK_NUM_CLIENTS; i++)
    begin
      m_limit[i] = '0;
      m_accum[i] = '0;
      m_cancel[i] = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    if (!req_ready || resp_valid)
      stop_run("req_ready low or resp_valid high right after reset");
    fd = $fopen("test/risk_gate_vectors.txt", "r");
    if (fd == 0)
      stop_run("cannot open test/risk_gate_vectors.txt");
    while (!$feof(fd))
    begin
      line = "";
      kind = "";
      void'($fgets(line, fd));
      void'($sscanf(line, "%s", kind));
      if (kind == "test")
        void'($sscanf(line, "%s %s", kind, test_name));
      else if (kind == "cancel")
      begin
        void'($sscanf(line, "%s %d %d", kind, c, ca));
        send_cancel(c, ca);
      end
      else if (kind == "req" || kind == "latency")
      begin
        void'($sscanf(line, "%s %d %d %d %s", kind, c, a, s, vtxt));
        file_v = parse_verdict(vtxt);
        // model must agree with the listed verdict
        check_verdict({test_name, " model"}, file_v, model_request(c, a, s));
        if (kind == "latency")
          wait_drain();
        send_request(c, a, s, file_v);
        if (kind == "latency")
          measure_latency();
      end
      else if (kind == "burst")
      begin
        void'($sscanf(line, "%s %d", kind, cnt));
        run_burst(cnt);
      end
    end
    $fclose(fd);
    wait_drain();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== test/risk_gate_vectors.txt ====
# test <name> | cancel <client> <amount> | burst <count>
# req or latency <client> <amount> <set_limit> <LIMIT|ACCEPT|REJECT>, decimal values
test reset_zero
req 0 0 0 ACCEPT
req 0 1 0 REJECT
test limit_fill
req 1 1000 1 LIMIT
req 1 400 0 ACCEPT
req 1 500 0 ACCEPT
req 1 200 0 REJECT
req 1 100 0 ACCEPT
req 1 1 0 REJECT
test cancel_headroom
cancel 1 50
req 1 50 0 ACCEPT
req 1 1 0 REJECT
cancel 4 500
req 4 100 0 ACCEPT
req 4 401 0 REJECT
req 4 400 0 ACCEPT
test cancel_saturate
cancel 2 60000
cancel 2 60000
req 2 100 1 LIMIT
req 2 65635 0 ACCEPT
req 2 1 0 REJECT
test independent
req 3 10 0 REJECT
req 1 0 0 ACCEPT
req 3 0 0 ACCEPT
test latency
latency 5 7 0 REJECT
test burst
burst 40
test after_burst
req 1 0 0 ACCEPT
req 2 0 0 ACCEPT
req 0 1 0 REJECT

// ==== sources.f ====
+incdir+hdl
hdl/order_pkg.sv
hdl/engine_pkg.sv
hdl/order_decode.sv
hdl/client_ledger.sv
hdl/cancel_ledger.sv
hdl/risk_execute.sv
hdl/order_result.sv
hdl/risk_gate_top.sv
test/risk_gate_tb.sv
